/* src/csr_defines.svh */
// Fixed RV32 machine-mode CSR constants, no supervisor mode
// Bit positions of mie and mip are shared since the layouts match

`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

`define CSR_XLEN 32

// CSR addresses
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MISA     12'h301
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343
`define CSR_ADDR_MIP      12'h344

// mstatus fields, MPP is the low bit of a 2-bit field
`define CSR_BIT_MIE  3
`define CSR_BIT_MPIE 7
`define CSR_BIT_MPP  11

// mie / mip machine interrupt bits
`define CSR_BIT_MSI 3
`define CSR_BIT_MTI 7
`define CSR_BIT_MEI 11

// Interrupt cause codes
`define CSR_CAUSE_MSI 3
`define CSR_CAUSE_MTI 7
`define CSR_CAUSE_MEI 11

// Exception cause codes
`define CSR_CAUSE_II  2
`define CSR_CAUSE_ECU 8
`define CSR_CAUSE_ECM 11

// MXL = 32, extensions I and U
`define CSR_MISA_VALUE 32'h40100100

`endif

/* src/csr_pkg.sv */
// Types shared by the CSR register block, the trap logic and the top level
// Width is fixed by CSR_XLEN, only M and U privilege exist

`default_nettype none

`include "csr_defines.svh"

package csr_pkg;

  typedef logic [`CSR_XLEN-1:0] xlen_t;
  typedef logic [11:0]          csr_addr_t;
  typedef logic [63:0]          time_t;

  typedef enum logic [1:0] {
    priv_user    = 2'b00,
    priv_machine = 2'b11
  } priv_e;

  // One register access, write strobe plus address
  typedef struct packed {
    logic      wr_en;
    csr_addr_t addr;
    xlen_t     wr_data;
  } csr_access_t;

  typedef struct packed {
    logic external;
    logic msip;
  } irq_lines_t;

  // Register view needed by the trap decision
  // enabled and pending are ordered {MEI, MTI, MSI}
  typedef struct packed {
    logic       global_ie;
    priv_e      mpp;
    logic [2:0] enabled;
    logic [2:0] pending;
    xlen_t      mtvec;
  } trap_state_t;

  // Trap decision fed back into the register block
  typedef struct packed {
    logic  take;
    logic  ret;
    logic  is_illegal;
    xlen_t cause;
    priv_e priv;
  } trap_event_t;

endpackage

`default_nettype wire

/* src/csr_file.sv */
// Machine-mode CSR storage, single-cycle write strobe and combinational read
// Writes are dropped in any cycle that takes a trap or accepts an mret
// Unlisted addresses read zero and flag addr_exception

`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_file import csr_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire csr_access_t access,
  input  wire irq_lines_t  irq,
  input  wire time_t       mtime,
  input  wire time_t       mtimecmp,
  input  wire xlen_t       pc,
  input  wire xlen_t       instruction,
  input  wire trap_event_t trap_event,
  output xlen_t            rd_data,
  output logic             addr_exception,
  output xlen_t            mepc,
  output trap_state_t      state
);

  // mstatus fields
  logic  status_mie;
  logic  status_mpie;
  priv_e status_mpp;

  // mie enable bits, {MEI, MTI, MSI}
  logic [2:0] irq_enable;
  logic [2:0] irq_pending;
  logic       mtip;

  xlen_t mtvec_q;
  xlen_t mscratch_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  xlen_t mtval_q;

  // Assembled read views
  xlen_t mstatus_word;
  xlen_t mie_word;
  xlen_t mip_word;

  logic       wr_ok;
  logic [1:0] new_mpp;
  logic       wr_mstatus;
  logic       wr_mie;
  logic       wr_mtvec;
  logic       wr_mscratch;
  logic       wr_mepc;
  logic       wr_mcause;
  logic       wr_mtval;

  // WLRL check, only causes this core can raise
  function automatic logic cause_legal(input xlen_t value);
    logic [`CSR_XLEN-2:0] code;
    code = value[`CSR_XLEN-2:0];
    if (value[`CSR_XLEN-1]) begin
      return (code == `CSR_CAUSE_MSI) || (code == `CSR_CAUSE_MTI) ||
             (code == `CSR_CAUSE_MEI);
    end
    return (code == `CSR_CAUSE_II) || (code == `CSR_CAUSE_ECU) ||
           (code == `CSR_CAUSE_ECM);
  endfunction

  // Write decode
  assign wr_ok       = access.wr_en & ~trap_event.take & ~trap_event.ret;
  assign wr_mstatus  = wr_ok && (access.addr == `CSR_ADDR_MSTATUS);
  assign wr_mie      = wr_ok && (access.addr == `CSR_ADDR_MIE);
  assign wr_mtvec    = wr_ok && (access.addr == `CSR_ADDR_MTVEC);
  assign wr_mscratch = wr_ok && (access.addr == `CSR_ADDR_MSCRATCH);
  assign wr_mepc     = wr_ok && (access.addr == `CSR_ADDR_MEPC);
  assign wr_mcause   = wr_ok && (access.addr == `CSR_ADDR_MCAUSE);
  assign wr_mtval    = wr_ok && (access.addr == `CSR_ADDR_MTVAL);

  assign new_mpp = access.wr_data[`CSR_BIT_MPP +: 2];

  // mstatus, trap entry and mret take precedence over software writes
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      status_mie  <= 1'b0;
      status_mpie <= 1'b0;
      status_mpp  <= priv_user;
    end else if (trap_event.take) begin
      status_mie  <= 1'b0;
      status_mpie <= status_mie;
      status_mpp  <= trap_event.priv;
    end else if (trap_event.ret) begin
      status_mie  <= status_mpie;
      status_mpie <= 1'b1;
      status_mpp  <= priv_user;
    end else if (wr_mstatus) begin
      status_mie  <= access.wr_data[`CSR_BIT_MIE];
      status_mpie <= access.wr_data[`CSR_BIT_MPIE];
      // Supervisor and reserved encodings are not supported
      if (new_mpp == priv_user || new_mpp == priv_machine) begin
        status_mpp <= priv_e'(new_mpp);
      end
    end
  end

  // Plain software registers
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq_enable <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
    end else begin
      if (wr_mie) begin
        irq_enable <= {access.wr_data[`CSR_BIT_MEI], access.wr_data[`CSR_BIT_MTI],
                       access.wr_data[`CSR_BIT_MSI]};
      end
      // Bit 1 is reserved in mtvec mode field
      if (wr_mtvec) begin
        mtvec_q <= {access.wr_data[`CSR_XLEN-1:2], 1'b0, access.wr_data[0]};
      end
      if (wr_mscratch) begin
        mscratch_q <= access.wr_data;
      end
    end
  end

  // Trap-updated registers
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc_q   <= '0;
      mcause_q <= '0;
      mtval_q  <= '0;
    end else if (trap_event.take) begin
      mepc_q   <= pc;
      mcause_q <= trap_event.cause;
      if (trap_event.is_illegal) begin
        mtval_q <= instruction;
      end
    end else begin
      if (wr_mepc) begin
        mepc_q <= {access.wr_data[`CSR_XLEN-1:2], 2'b00};
      end
      if (wr_mcause && cause_legal(access.wr_data)) begin
        mcause_q <= access.wr_data;
      end
      if (wr_mtval) begin
        mtval_q <= access.wr_data;
      end
    end
  end

  // Pending bits come straight from the platform, not writable here
  assign mtip        = mtime >= mtimecmp;
  assign irq_pending = {irq.external, mtip, irq.msip};

  always_comb begin
    mstatus_word = '0;
    mstatus_word[`CSR_BIT_MIE]      = status_mie;
    mstatus_word[`CSR_BIT_MPIE]     = status_mpie;
    mstatus_word[`CSR_BIT_MPP +: 2] = status_mpp;

    mie_word = '0;
    mie_word[`CSR_BIT_MSI] = irq_enable[0];
    mie_word[`CSR_BIT_MTI] = irq_enable[1];
    mie_word[`CSR_BIT_MEI] = irq_enable[2];

    mip_word = '0;
    mip_word[`CSR_BIT_MSI] = irq_pending[0];
    mip_word[`CSR_BIT_MTI] = irq_pending[1];
    mip_word[`CSR_BIT_MEI] = irq_pending[2];
  end

  // Read mux
  always_comb begin
    rd_data        = '0;
    addr_exception = 1'b0;
    case (access.addr)
      `CSR_ADDR_MSTATUS:  rd_data = mstatus_word;
      `CSR_ADDR_MISA:     rd_data = `CSR_MISA_VALUE;
      `CSR_ADDR_MIE:      rd_data = mie_word;
      `CSR_ADDR_MTVEC:    rd_data = mtvec_q;
      `CSR_ADDR_MSCRATCH: rd_data = mscratch_q;
      `CSR_ADDR_MEPC:     rd_data = mepc_q;
      `CSR_ADDR_MCAUSE:   rd_data = mcause_q;
      `CSR_ADDR_MTVAL:    rd_data = mtval_q;
      `CSR_ADDR_MIP:      rd_data = mip_word;
      default:            addr_exception = 1'b1;
    endcase
  end

  assign mepc = mepc_q;

  // View handed to the trap logic
  assign state.global_ie = status_mie;
  assign state.mpp       = status_mpp;
  assign state.enabled   = irq_enable;
  assign state.pending   = irq_pending;
  assign state.mtvec     = mtvec_q;

endmodule

`default_nettype wire

/* src/trap_control.sv */
// Trap arbitration and privilege tracking for an M/U core
// Exceptions are always taken, MIE only gates interrupts in machine mode
// Privilege checks on CSR accesses and mret are done outside

`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module trap_control import csr_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire trap_state_t state,
  input  wire logic        illegal_instruction,
  input  wire logic        ecall,
  input  wire logic        mret,
  output trap_event_t      trap_event,
  output logic             trap,
  output xlen_t            trap_addr,
  output priv_e            privilege_mode
);

  priv_e priv_q;

  // Interrupt vector, {MEI, MTI, MSI}
  logic [2:0] irq_active;
  logic       irq_allow;
  logic       is_irq;
  logic       take;
  logic       ret;

  // Cause code without the interrupt bit
  xlen_t code;
  xlen_t cause;

  xlen_t vector_base;
  xlen_t vector_offset;

  // User mode can always be interrupted by a machine interrupt
  assign irq_allow  = (priv_q == priv_user) | state.global_ie;
  assign irq_active = state.pending & state.enabled & {3{irq_allow}};
  assign is_irq     = |irq_active;

  // Priority, MEI > MTI > MSI > illegal > ecall
  always_comb begin
    code = '0;
    if (irq_active[2]) begin
      code = xlen_t'(`CSR_CAUSE_MEI);
    end else if (irq_active[1]) begin
      code = xlen_t'(`CSR_CAUSE_MTI);
    end else if (irq_active[0]) begin
      code = xlen_t'(`CSR_CAUSE_MSI);
    end else if (illegal_instruction) begin
      code = xlen_t'(`CSR_CAUSE_II);
    end else if (ecall) begin
      if (priv_q == priv_user) begin
        code = xlen_t'(`CSR_CAUSE_ECU);
      end else begin
        code = xlen_t'(`CSR_CAUSE_ECM);
      end
    end
  end

  assign cause = {is_irq, code[`CSR_XLEN-2:0]};

  assign take = is_irq | illegal_instruction | ecall;
  // A trap in the same cycle wins over mret
  assign ret  = mret & ~take;

  // Trap target, vectored mode only applies to interrupts
  assign vector_base   = {state.mtvec[`CSR_XLEN-1:2], 2'b00};
  assign vector_offset = (state.mtvec[0] && is_irq) ? (code << 2) : '0;
  assign trap_addr     = vector_base + vector_offset;

  assign trap = take;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      priv_q <= priv_machine;
    end else if (take) begin
      priv_q <= priv_machine;
    end else if (ret) begin
      priv_q <= state.mpp;
    end
  end

  assign privilege_mode = priv_q;

  // Event for the register block
  assign trap_event.take       = take;
  assign trap_event.ret        = ret;
  assign trap_event.is_illegal = ~is_irq & illegal_instruction;
  assign trap_event.cause      = cause;
  assign trap_event.priv       = priv_q;

endmodule

`default_nettype wire

/* src/csr_unit.sv */
// Machine-mode CSR unit for an RV32 core with M and U privilege
// mret together with a write strobe is an invalid input
// Reads are combinational, updates land on the next rising edge

`timescale 1ns/1ps
`default_nettype none

module csr_unit import csr_pkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire csr_access_t access,
  input  wire irq_lines_t  irq,
  input  wire time_t       mtime,
  input  wire time_t       mtimecmp,
  input  wire xlen_t       pc,
  input  wire xlen_t       instruction,
  input  wire logic        illegal_instruction,
  input  wire logic        ecall,
  input  wire logic        mret,
  output wire xlen_t       rd_data,
  output wire logic        addr_exception,
  output wire xlen_t       mepc,
  output wire logic        trap,
  output wire xlen_t       trap_addr,
  output wire priv_e       privilege_mode
);

  trap_state_t state;
  trap_event_t trap_event;

  csr_file u_csr_file (
    .clock          (clock),
    .reset          (reset),
    .access         (access),
    .irq            (irq),
    .mtime          (mtime),
    .mtimecmp       (mtimecmp),
    .pc             (pc),
    .instruction    (instruction),
    .trap_event     (trap_event),
    .rd_data        (rd_data),
    .addr_exception (addr_exception),
    .mepc           (mepc),
    .state          (state)
  );

  trap_control u_trap_control (
    .clock               (clock),
    .reset               (reset),
    .state               (state),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .mret                (mret),
    .trap_event          (trap_event),
    .trap                (trap),
    .trap_addr           (trap_addr),
    .privilege_mode      (privilege_mode)
  );

endmodule

`default_nettype wire

/* bench/csr_tests.svh */
// Stimulus and expected-value table for the CSR unit testbench
// Included inside the testbench module, uses its seed, pc_value and insn_value

`ifndef CSR_TESTS_SVH
`define CSR_TESTS_SVH

// One cycle of stimulus and the outputs expected before the next edge
// strobe is {illegal_instruction, ecall, mret}, irq_set is {external, msip, timer}
typedef struct {
  string      name;
  logic       wr_en;
  csr_addr_t  addr;
  xlen_t      wr_data;
  logic [2:0] strobe;
  logic [2:0] irq_set;
  xlen_t      exp_rd;
  logic       exp_addr_exc;
  logic       exp_trap;
  xlen_t      exp_trap_addr;
  priv_e      exp_priv;
} test_row_t;

test_row_t test_rows[$];

function automatic test_row_t make_row(
  input string     name,
  input logic      wr_en,
  input csr_addr_t addr,
  input xlen_t     wr_data,
  input xlen_t     exp_rd,
  input priv_e     exp_priv
);
  test_row_t row;
  row.name          = name;
  row.wr_en         = wr_en;
  row.addr          = addr;
  row.wr_data       = wr_data;
  row.strobe        = 3'b000;
  row.irq_set       = 3'b000;
  row.exp_rd        = exp_rd;
  row.exp_addr_exc  = 1'b0;
  row.exp_trap      = 1'b0;
  row.exp_trap_addr = '0;
  row.exp_priv      = exp_priv;
  return row;
endfunction

function automatic test_row_t expect_trap(input test_row_t row, input xlen_t target);
  test_row_t result;
  result               = row;
  result.exp_trap      = 1'b1;
  result.exp_trap_addr = target;
  return result;
endfunction

// Expected mstatus read value, every other bit reads zero
function automatic xlen_t status_word(
  input logic [1:0] mpp,
  input logic       mpie,
  input logic       mie
);
  xlen_t word;
  word                     = '0;
  word[`CSR_BIT_MPP +: 2]  = mpp;
  word[`CSR_BIT_MPIE]      = mpie;
  word[`CSR_BIT_MIE]       = mie;
  return word;
endfunction

task automatic add_row(input test_row_t row);
  test_rows.push_back(row);
endtask

task automatic build_tests();
  test_row_t row;
  xlen_t     scratch;
  xlen_t     tvec;
  xlen_t     epc;
  xlen_t     base;
  xlen_t     irq_bits;
  scratch    = $random(seed);
  tvec       = $random(seed);
  epc        = $random(seed);
  base       = $random(seed) & ~32'h3;
  pc_value   = $random(seed) & ~32'h3;
  insn_value = $random(seed);
  irq_bits   = (32'h1 << `CSR_BIT_MSI) | (32'h1 << `CSR_BIT_MTI) | (32'h1 << `CSR_BIT_MEI);

  add_row(make_row("reset_misa", 1'b0, `CSR_ADDR_MISA, 32'h0, `CSR_MISA_VALUE, priv_machine));
  row = make_row("reset_bad_addr", 1'b0, 12'h7C0, 32'h0, 32'h0, priv_machine);
  row.exp_addr_exc = 1'b1;
  add_row(row);

  // Each write row reads the value held before its own write
  add_row(make_row("wr_mscratch", 1'b1, `CSR_ADDR_MSCRATCH, scratch, 32'h0, priv_machine));
  add_row(make_row("rd_mscratch", 1'b0, `CSR_ADDR_MSCRATCH, 32'h0, scratch, priv_machine));
  add_row(make_row("wr_mtvec", 1'b1, `CSR_ADDR_MTVEC, tvec, 32'h0, priv_machine));
  add_row(make_row("rd_mtvec", 1'b0, `CSR_ADDR_MTVEC, 32'h0, tvec & ~32'h2, priv_machine));
  add_row(make_row("wr_mepc", 1'b1, `CSR_ADDR_MEPC, epc, 32'h0, priv_machine));
  add_row(make_row("rd_mepc", 1'b0, `CSR_ADDR_MEPC, 32'h0, epc & ~32'h3, priv_machine));
  // Reset mstatus reads zero here
  add_row(make_row("wr_mpp_2", 1'b1, `CSR_ADDR_MSTATUS, status_word(2'b10, 1'b0, 1'b1),
                   32'h0, priv_machine));
  add_row(make_row("rd_mpp_kept", 1'b0, `CSR_ADDR_MSTATUS, 32'h0,
                   status_word(2'b00, 1'b0, 1'b1), priv_machine));
  add_row(make_row("wr_mcause_5", 1'b1, `CSR_ADDR_MCAUSE, 32'h5, 32'h0, priv_machine));
  add_row(make_row("wr_mcause_8", 1'b1, `CSR_ADDR_MCAUSE, 32'h8, 32'h0, priv_machine));
  add_row(make_row("rd_mcause_8", 1'b0, `CSR_ADDR_MCAUSE, 32'h0, 32'h8, priv_machine));

  // Machine ecall with a write that has to be dropped
  row = make_row("ecall_machine", 1'b1, `CSR_ADDR_MSCRATCH, ~scratch, scratch, priv_machine);
  row.strobe = 3'b010;
  add_row(expect_trap(row, tvec & ~32'h3));
  add_row(make_row("rd_mcause_ecm", 1'b0, `CSR_ADDR_MCAUSE, 32'h0, `CSR_CAUSE_ECM,
                   priv_machine));
  add_row(make_row("rd_mepc_pc", 1'b0, `CSR_ADDR_MEPC, 32'h0, pc_value, priv_machine));
  add_row(make_row("rd_mscratch_kept", 1'b0, `CSR_ADDR_MSCRATCH, 32'h0, scratch, priv_machine));
  add_row(make_row("wr_mpp_user", 1'b1, `CSR_ADDR_MSTATUS, status_word(2'b00, 1'b1, 1'b0),
                   status_word(2'b11, 1'b1, 1'b0), priv_machine));

  // mret to user, then a user ecall
  row = make_row("mret_user", 1'b0, `CSR_ADDR_MSTATUS, 32'h0, status_word(2'b00, 1'b1, 1'b0),
                 priv_machine);
  row.strobe = 3'b001;
  add_row(row);
  row = make_row("ecall_user", 1'b0, `CSR_ADDR_MSTATUS, 32'h0, status_word(2'b00, 1'b1, 1'b1),
                 priv_user);
  row.strobe = 3'b010;
  add_row(expect_trap(row, tvec & ~32'h3));
  add_row(make_row("rd_mcause_ecu", 1'b0, `CSR_ADDR_MCAUSE, 32'h0, `CSR_CAUSE_ECU,
                   priv_machine));

  row = make_row("illegal", 1'b0, `CSR_ADDR_MTVAL, 32'h0, 32'h0, priv_machine);
  row.strobe = 3'b100;
  add_row(expect_trap(row, tvec & ~32'h3));
  add_row(make_row("rd_mtval", 1'b0, `CSR_ADDR_MTVAL, 32'h0, insn_value, priv_machine));
  add_row(make_row("rd_mcause_ii", 1'b0, `CSR_ADDR_MCAUSE, 32'h0, `CSR_CAUSE_II, priv_machine));

  // Interrupt setup: MIE clear, all enables set, vectored mtvec
  add_row(make_row("wr_mstatus_zero", 1'b1, `CSR_ADDR_MSTATUS, 32'h0,
                   status_word(2'b11, 1'b0, 1'b0), priv_machine));
  add_row(make_row("wr_mie", 1'b1, `CSR_ADDR_MIE, irq_bits, 32'h0, priv_machine));
  add_row(make_row("wr_mtvec_vec", 1'b1, `CSR_ADDR_MTVEC, base | 32'h1, tvec & ~32'h2,
                   priv_machine));
  row = make_row("mret_to_user", 1'b0, `CSR_ADDR_MIE, 32'h0, irq_bits, priv_machine);
  row.strobe = 3'b001;
  add_row(row);
  row = make_row("timer_user", 1'b0, `CSR_ADDR_MIP, 32'h0, 32'h1 << `CSR_BIT_MTI, priv_user);
  row.irq_set = 3'b001;
  add_row(expect_trap(row, base + 4 * `CSR_CAUSE_MTI));
  row = make_row("mret_again", 1'b0, `CSR_ADDR_MCAUSE, 32'h0,
                 32'h8000_0000 | `CSR_CAUSE_MTI, priv_machine);
  row.strobe = 3'b001;
  add_row(row);
  row = make_row("all_irq_user", 1'b0, `CSR_ADDR_MIP, 32'h0, irq_bits, priv_user);
  row.irq_set = 3'b111;
  add_row(expect_trap(row, base + 4 * `CSR_CAUSE_MEI));
  // Machine mode with MIE clear keeps every interrupt waiting
  row = make_row("machine_masked", 1'b0, `CSR_ADDR_MCAUSE, 32'h0,
                 32'h8000_0000 | `CSR_CAUSE_MEI, priv_machine);
  row.irq_set = 3'b111;
  add_row(row);
endtask

`endif

/* bench/csr_unit_tb.sv */
// Table-driven testbench for the CSR unit, one table row per clock cycle
// Inputs change 1 ns after the rising edge, outputs are checked 0.5 ns before the next

`timescale 1ns/1ps
`default_nettype none

`include "csr_defines.svh"

module csr_unit_tb import csr_pkg::*; ();

  logic        clock;
  logic        reset;
  csr_access_t access;
  irq_lines_t  irq;
  time_t       mtime;
  time_t       mtimecmp;
  xlen_t       pc;
  xlen_t       instruction;
  logic        illegal_instruction;
  logic        ecall;
  logic        mret;
  xlen_t       rd_data;
  logic        addr_exception;
  xlen_t       mepc;
  logic        trap;
  xlen_t       trap_addr;
  priv_e       privilege_mode;

  int    seed = 65;
  xlen_t pc_value;
  xlen_t insn_value;
  int    error_count = 0;
  int    cycle_count = 0;
  int    cycle_limit = 0;

  // mtime sits one below this unless a row raises the timer
  localparam time_t timer_cmp = 64'h0000_0001_0000_0040;

  `include "csr_tests.svh"

  csr_unit UUT (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles, the test table did not complete", cycle_count);
      $display("Something failed");
      $fatal(1, "Timeout");
    end
  end

  task automatic apply_row(input test_row_t row);
    access.wr_en        = row.wr_en;
    access.addr         = row.addr;
    access.wr_data      = row.wr_data;
    illegal_instruction = row.strobe[2];
    ecall               = row.strobe[1];
    mret                = row.strobe[0];
    irq.external        = row.irq_set[2];
    irq.msip            = row.irq_set[1];
    mtimecmp            = timer_cmp;
    mtime               = row.irq_set[0] ? timer_cmp : timer_cmp - 64'd1;
    pc                  = pc_value;
    instruction         = insn_value;
  endtask

  task automatic report_mismatch(input string name, input string signal,
                                 input xlen_t expected, input xlen_t actual);
    error_count++;
    $display("[ERROR] %s: %s expected %h, actual %h", name, signal, expected, actual);
    $display("Something failed");
    $fatal(1, "Check failed in %s", name);
  endtask

  task automatic check_row(input test_row_t row);
    assert (rd_data === row.exp_rd)
      else report_mismatch(row.name, "rd_data", row.exp_rd, rd_data);
    assert (addr_exception === row.exp_addr_exc)
      else report_mismatch(row.name, "addr_exception", xlen_t'(row.exp_addr_exc),
                           xlen_t'(addr_exception));
    assert (trap === row.exp_trap)
      else report_mismatch(row.name, "trap", xlen_t'(row.exp_trap), xlen_t'(trap));
    // trap_addr only matters while a trap is taken
    if (row.exp_trap) begin
      assert (trap_addr === row.exp_trap_addr)
        else report_mismatch(row.name, "trap_addr", row.exp_trap_addr, trap_addr);
    end
    // The mepc port shows the same value as a read of mepc
    if (row.addr == `CSR_ADDR_MEPC) begin
      assert (mepc === row.exp_rd)
        else report_mismatch(row.name, "mepc", row.exp_rd, mepc);
    end
    assert (privilege_mode === row.exp_priv)
      else report_mismatch(row.name, "privilege_mode", xlen_t'(row.exp_priv),
                           xlen_t'(privilege_mode));
  endtask

  initial begin
    build_tests();
    apply_row(make_row("idle", 1'b0, `CSR_ADDR_MISA, 32'h0, 32'h0, priv_machine));
    reset       = 1'b1;
    cycle_limit = test_rows.size() + 20;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    foreach (test_rows[i]) begin
      apply_row(test_rows[i]);
      #2.5;
      check_row(test_rows[i]);
      @(posedge clock);
      #1;
    end
    if (error_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
+incdir+bench
src/csr_pkg.sv
src/csr_file.sv
src/trap_control.sv
src/csr_unit.sv
bench/csr_unit_tb.sv

/* Bender.yml */
package:
  name: csr_unit

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/csr_file.sv
      - src/trap_control.sv
      - src/csr_unit.sv
  - target: test
    include_dirs:
      - src
      - bench
    files:
      - bench/csr_unit_tb.sv
